// ==== simple_ipod.f ====
verilog/simple_ipod_pkg.sv
verilog/playback_control.sv
verilog/flash_reader.sv
verilog/sample_fifo.sv
verilog/sample_player.sv
verilog/simple_ipod.sv
bench/flash_model.sv
bench/simple_ipod_tb.sv

// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = simple_ipod_tb
FILELIST = simple_ipod.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build folder and the log"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "Simulation finished: PASS" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// ==== bench/simple_ipod_tb.sv ====
`default_nettype none

module simple_ipod_tb;

  timeunit 1ns;
  timeprecision 100ps;

  import simple_ipod_pkg::*;

  localparam int PLANNED_SAMPLES = 250;  // Sample slots, drain windows included
  localparam int TIMEOUT_CYCLES  = PLANNED_SAMPLES * int'(PERIOD_MAX) * 2;
  localparam int DRAIN_PERIODS   = FIFO_DEPTH + 2;

  logic        clk = 1'b0;
  logic        reset;
  ascii_t      key_ascii;
  logic        key_valid;
  logic        speed_up;
  logic        speed_down;
  logic        speed_reset;
  logic        wb_cyc;
  logic        wb_stb;
  flash_addr_t wb_adr;
  flash_word_t wb_rdata;
  logic        wb_ack;
  sample_t     audio_sample;
  logic        sample_valid;

  // Written by the stimulus only
  logic        quiet;  // No samples and no bus cycles expected
  logic        model_forward;
  period_t     model_period;
  flash_addr_t restart_addr;
  int          restart_id;
  int          change_id;

  // Written by the bus monitor only
  int          cycle_count = 0;
  flash_addr_t bus_addr;  // Next word the reader should fetch
  int          bus_seen_restart;

  // Written by the compare process only
  int          idle_cycles;
  int          last_pulse;
  int          since_change;
  int          seen_restart;
  int          seen_change;
  int          samples_checked;
  flash_addr_t exp_addr;
  logic        second_half;

  simple_ipod dut_i (
    .clk, .reset, .key_ascii, .key_valid, .speed_up, .speed_down, .speed_reset,
    .wb_cyc, .wb_stb, .wb_adr, .wb_rdata, .wb_ack, .audio_sample, .sample_valid
  );

  flash_model flash_i (.clk, .reset, .wb_cyc, .wb_stb, .wb_adr, .wb_rdata, .wb_ack);

  always #2 clk = ~clk;

  // ========================================
  // Reference model
  // ========================================
  function automatic sample_t expected_sample(flash_addr_t a, logic fwd, logic second);
    flash_word_t w;
    w = {~a[22:7], a[15:0]};
    if (fwd) return second ? sample_t'(w[15:0]) : sample_t'(w[31:16]);
    return second ? sample_t'(w[31:16]) : sample_t'(w[15:0]);
  endfunction

  function automatic flash_addr_t next_addr(flash_addr_t a, logic fwd);
    if (fwd) return (a == LAST_WORD_ADDR) ? flash_addr_t'(0) : a + 23'd1;
    return (a == '0) ? LAST_WORD_ADDR : a - 23'd1;
  endfunction

  function automatic period_t next_period(period_t p, logic up, logic down, logic rst);
    int v;
    v = int'(p);
    if (rst) v = int'(SAMPLE_PERIOD_BASE);
    else if (up) v = v - int'(PERIOD_STEP);
    else if (down) v = v + int'(PERIOD_STEP);
    if (v < int'(PERIOD_MIN)) v = int'(PERIOD_MIN);
    if (v > int'(PERIOD_MAX)) v = int'(PERIOD_MAX);
    return period_t'(v);
  endfunction

  // ========================================
  // Checks
  // ========================================
  task automatic report_failure(string what);
    $display("%s", what);
    $display("Simulation finished: FAIL");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic check_sample(string name, sample_t got, sample_t exp);
    if (got !== exp) report_failure($sformatf("CHECK FAILED %s: got 0x%h expected 0x%h",
                                              name, got, exp));
  endtask

  task automatic check_period(string name, period_t got, period_t exp);
    if (got !== exp) report_failure($sformatf("CHECK FAILED %s: got 0x%h expected 0x%h",
                                              name, got, exp));
  endtask

  task automatic check_addr(string name, flash_addr_t got, flash_addr_t exp);
    if (got !== exp) report_failure($sformatf("CHECK FAILED %s: got 0x%h expected 0x%h",
                                              name, got, exp));
  endtask

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) report_failure("Timeout before all tests completed");
    if (reset) begin
      bus_addr         = '0;
      bus_seen_restart = 0;
    end else begin
      if (quiet && wb_cyc) report_failure("Bus cycle started while playback was stopped");
      if (wb_stb !== wb_cyc) report_failure("wb_stb and wb_cyc did not move together");
      if (wb_cyc && wb_ack) begin
        if (restart_id != bus_seen_restart) begin
          bus_addr         = restart_addr;
          bus_seen_restart = restart_id;
        end
        check_addr("wb_adr", wb_adr, bus_addr);
        bus_addr = next_addr(bus_addr, model_forward);
      end
    end
  end

  always @(posedge clk) begin
    if (reset) begin
      exp_addr        = '0;
      second_half     = 1'b0;
      seen_restart    = 0;
      seen_change     = 0;
      since_change    = 0;
      idle_cycles     = 0;
      last_pulse      = 0;
      samples_checked = 0;
    end else if (sample_valid) begin
      if (quiet) report_failure("sample_valid pulsed while playback was stopped");
      if (restart_id != seen_restart) begin
        exp_addr     = restart_addr;
        seen_restart = restart_id;
      end
      if (change_id != seen_change) begin
        since_change = 0;
        seen_change  = change_id;
      end
      check_sample("audio_sample", audio_sample,
                   expected_sample(exp_addr, model_forward, second_half));
      since_change = since_change + 1;
      // Earlier gaps may span the change
      if (since_change >= 3) begin
        check_period("sample_valid gap", period_t'(cycle_count - last_pulse), model_period);
      end
      last_pulse = cycle_count;
      if (second_half) exp_addr = next_addr(exp_addr, model_forward);
      second_half     = !second_half;
      samples_checked = samples_checked + 1;
      idle_cycles     = 0;
    end else begin
      idle_cycles = idle_cycles + 1;
    end
  end

  // ========================================
  // Stimulus
  // ========================================
  task automatic press_key(ascii_t code);
    @(posedge clk);
    #1;
    key_ascii = code;
    key_valid = 1'b1;
    @(posedge clk);
    #1;
    key_valid = 1'b0;
  endtask

  task automatic speed_pulse(logic up, logic down, logic rst);
    @(posedge clk);
    #1;
    speed_up     = up;
    speed_down   = down;
    speed_reset  = rst;
    model_period = next_period(model_period, up, down, rst);
    change_id    = change_id + 1;
    @(posedge clk);
    #1;
    speed_up    = 1'b0;
    speed_down  = 1'b0;
    speed_reset = 1'b0;
  endtask

  task automatic resume_play(ascii_t code);
    quiet     = 1'b0;
    change_id = change_id + 1;
    press_key(code);
  endtask

  // Pause, then wait out a full window with no samples
  task automatic pause_and_drain(ascii_t code);
    press_key(code);
    while (idle_cycles < DRAIN_PERIODS * int'(model_period)) begin
      @(posedge clk);
      #1;
    end
    quiet = 1'b1;
  endtask

  task automatic wait_samples(int n);
    int target;
    target = samples_checked + n;
    while (samples_checked < target) begin
      @(posedge clk);
      #1;
    end
  endtask

  task automatic restart_model(flash_addr_t a);
    restart_addr = a;
    restart_id   = restart_id + 1;
  endtask

  initial begin
    reset         = 1'b1;
    key_ascii     = '0;
    key_valid     = 1'b0;
    speed_up      = 1'b0;
    speed_down    = 1'b0;
    speed_reset   = 1'b0;
    quiet         = 1'b1;
    model_forward = 1'b1;
    model_period  = SAMPLE_PERIOD_BASE;
    restart_addr  = '0;
    restart_id    = 0;
    change_id     = 0;
    repeat (4) @(posedge clk);
    #1;
    reset = 1'b0;
    repeat (2 * int'(SAMPLE_PERIOD_BASE)) @(posedge clk);  // Idle after reset

    resume_play(KEY_UPPER_E);  // Forward from word 0
    wait_samples(8);
    pause_and_drain(KEY_UPPER_D);
    resume_play(KEY_LOWER_E);
    wait_samples(6);
    pause_and_drain(KEY_LOWER_D);

    press_key(KEY_UPPER_B);
    model_forward = 1'b0;
    resume_play(KEY_UPPER_E);
    wait_samples(6);
    pause_and_drain(KEY_UPPER_D);
    press_key(KEY_LOWER_F);
    model_forward = 1'b1;
    resume_play(KEY_UPPER_E);
    wait_samples(4);
    pause_and_drain(KEY_UPPER_D);

    // Restart then backward across the wrap
    press_key(KEY_UPPER_R);
    restart_model('0);
    press_key(KEY_LOWER_B);
    model_forward = 1'b0;
    resume_play(KEY_LOWER_E);
    wait_samples(6);
    pause_and_drain(KEY_UPPER_D);
    press_key(KEY_LOWER_R);
    restart_model(LAST_WORD_ADDR);
    resume_play(KEY_UPPER_E);
    wait_samples(4);
    pause_and_drain(KEY_UPPER_D);

    press_key(8'h78);  // x
    press_key(8'h51);  // Q
    repeat (2 * int'(model_period)) @(posedge clk);

    press_key(KEY_UPPER_F);
    model_forward = 1'b1;
    resume_play(KEY_UPPER_E);
    wait_samples(3);
    repeat (3) speed_pulse(1'b1, 1'b0, 1'b0);
    wait_samples(5);
    repeat (60) speed_pulse(1'b1, 1'b0, 1'b0);
    wait_samples(5);
    repeat (45) speed_pulse(1'b0, 1'b1, 1'b0);
    wait_samples(4);
    speed_pulse(1'b0, 1'b0, 1'b1);
    wait_samples(4);
    pause_and_drain(KEY_UPPER_D);

    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

`default_nettype wire

// ==== bench/flash_model.sv ====
`default_nettype none

module flash_model (
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         wb_cyc,
  input  logic                         wb_stb,
  input  simple_ipod_pkg::flash_addr_t wb_adr,
  output simple_ipod_pkg::flash_word_t wb_rdata,
  output logic                         wb_ack
);

  timeunit 1ns;
  timeprecision 100ps;

  import simple_ipod_pkg::*;

  int unsigned wait_left;
  logic        busy;
  logic        seeded = 1'b0;

  // Complemented high address bits on top, low address bits below
  function automatic flash_word_t word_at(flash_addr_t a);
    return {~a[22:7], a[15:0]};
  endfunction

  always @(posedge clk or posedge reset) begin
    if (reset) begin
      if (!seeded) begin
        void'($urandom(40));
        seeded = 1'b1;
      end
      wb_ack    <= 1'b0;
      wb_rdata  <= '0;
      busy      = 1'b0;
      wait_left = 0;
    end else begin
      wb_ack <= 1'b0;
      if (wb_cyc && wb_stb && !wb_ack) begin
        if (!busy) begin
          busy      = 1'b1;
          wait_left = $urandom % 4;  // Zero to three wait states
        end
        if (wait_left == 0) begin
          wb_ack   <= 1'b1;
          wb_rdata <= word_at(wb_adr);
          busy     = 1'b0;
        end else begin
          wait_left = wait_left - 1;
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== verilog/simple_ipod.sv ====
`default_nettype none

module simple_ipod (
  input  logic                          clk,
  input  logic                          reset,
  input  simple_ipod_pkg::ascii_t       key_ascii,
  input  logic                          key_valid,
  input  logic                          speed_up,
  input  logic                          speed_down,
  input  logic                          speed_reset,
  output logic                          wb_cyc,
  output logic                          wb_stb,
  output simple_ipod_pkg::flash_addr_t  wb_adr,
  input  simple_ipod_pkg::flash_word_t  wb_rdata,
  input  logic                          wb_ack,
  output simple_ipod_pkg::sample_t      audio_sample,
  output logic                          sample_valid
);

  import simple_ipod_pkg::*;

  // Control to datapath
  logic    playing;
  logic    forward;
  logic    restart;
  period_t sample_period;

  // Producer, buffer and consumer
  logic                    push;
  sample_t                 push_data;
  logic                    pop;
  sample_t                 pop_data;
  logic                    empty;
  logic [FIFO_COUNT_W-1:0] count;

  playback_control control_i (
    .clk, .reset, .key_ascii, .key_valid, .speed_up, .speed_down, .speed_reset,
    .playing, .forward, .restart, .sample_period
  );

  flash_reader reader_i (
    .clk, .reset, .playing, .forward, .restart, .count,
    .wb_cyc, .wb_stb, .wb_adr, .wb_rdata, .wb_ack,
    .push, .push_data
  );

  sample_fifo #(
    .payload_t (sample_t)
  ) fifo_i (
    .clk, .reset, .push, .push_data, .pop, .pop_data, .empty, .count
  );

  sample_player player_i (
    .clk, .reset, .sample_period, .empty, .pop, .pop_data,
    .audio_sample, .sample_valid
  );

endmodule

`default_nettype wire

// ==== verilog/sample_player.sv ====
`default_nettype none

module sample_player (
  input  logic                      clk,
  input  logic                      reset,
  input  simple_ipod_pkg::period_t  sample_period,
  input  logic                      empty,
  output logic                      pop,
  input  simple_ipod_pkg::sample_t  pop_data,
  output simple_ipod_pkg::sample_t  audio_sample,
  output logic                      sample_valid
);

  import simple_ipod_pkg::*;

  period_t cnt;
  period_t period_q;  // Period of the running interval
  logic    tick;

  assign tick = (cnt == period_q - 1'b1);
  assign pop  = tick && !empty;

  // ========================================
  // Sample-period divider
  // ========================================
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      cnt      <= '0;
      period_q <= SAMPLE_PERIOD_BASE;
    end else if (tick) begin
      cnt      <= '0;
      period_q <= sample_period;  // New value counts from here on
    end else begin
      cnt <= cnt + 1'b1;
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      sample_valid <= 1'b0;
    end else begin
      sample_valid <= pop;
    end
  end

  // Holds the last sample through an empty tick
  always_ff @(posedge clk) begin
    if (pop) audio_sample <= pop_data;
  end

  // Minimum period keeps output strobes apart
  assert property (@(posedge clk) disable iff (reset)
    sample_valid |=> !sample_valid);

endmodule

`default_nettype wire

// ==== verilog/sample_fifo.sv ====
`default_nettype none

module sample_fifo #(
  parameter type payload_t = logic
) (
  input  logic                                     clk,
  input  logic                                     reset,
  input  logic                                     push,
  input  payload_t                                 push_data,
  input  logic                                     pop,
  output payload_t                                 pop_data,
  output logic                                     empty,
  output logic [simple_ipod_pkg::FIFO_COUNT_W-1:0] count
);

  import simple_ipod_pkg::*;

  payload_t              mem [FIFO_DEPTH];
  logic [FIFO_PTR_W-1:0] wr_ptr;
  logic [FIFO_PTR_W-1:0] rd_ptr;
  logic                  full;
  logic                  do_push;
  logic                  do_pop;

  assign full    = (count == FIFO_COUNT_W'(FIFO_DEPTH));
  assign empty   = (count == '0);
  assign do_push = push && !full;
  assign do_pop  = pop && !empty;

  // ========================================
  // Storage
  // ========================================
  always_ff @(posedge clk) begin
    if (do_push) mem[wr_ptr] <= push_data;
  end

  assign pop_data = mem[rd_ptr];  // Head entry, shown ahead of pop

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= (wr_ptr == FIFO_PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == FIFO_PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // Both or neither
      endcase
    end
  end

  // Producer must throttle on count, consumer on empty
  assert property (@(posedge clk) disable iff (reset) !(push && full));
  assert property (@(posedge clk) disable iff (reset) !(pop && empty));

endmodule

`default_nettype wire

// ==== verilog/flash_reader.sv ====
`default_nettype none

module flash_reader (
  input  logic                                       clk,
  input  logic                                       reset,
  input  logic                                       playing,
  input  logic                                       forward,
  input  logic                                       restart,
  input  logic [simple_ipod_pkg::FIFO_COUNT_W-1:0]   count,
  output logic                                       wb_cyc,
  output logic                                       wb_stb,
  output simple_ipod_pkg::flash_addr_t               wb_adr,
  input  simple_ipod_pkg::flash_word_t               wb_rdata,
  input  logic                                       wb_ack,
  output logic                                       push,
  output simple_ipod_pkg::sample_t                   push_data
);

  import simple_ipod_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_READ,
    ST_PUSH_FIRST,
    ST_PUSH_SECOND
  } state_t;

  state_t      state;
  flash_addr_t addr;
  flash_addr_t addr_step;     // Neighbour word in current direction
  flash_word_t word_q;
  logic        word_forward;  // Split order for the word in hand
  logic        restart_pending;
  logic        start_read;

  // Only when two entries are free, so both halves always fit
  assign start_read = playing && (state == ST_IDLE) && (count <= FIFO_DEPTH - 2);

  always_comb begin
    if (forward) begin
      addr_step = (addr == LAST_WORD_ADDR) ? '0 : addr + 1'b1;
    end else begin
      addr_step = (addr == '0) ? LAST_WORD_ADDR : addr - 1'b1;
    end
  end

  // ========================================
  // Read sequencing
  // ========================================
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state           <= ST_IDLE;
      addr            <= '0;
      word_forward    <= 1'b1;
      restart_pending <= 1'b0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (restart) begin
            addr <= forward ? '0 : LAST_WORD_ADDR;
          end
          if (start_read) begin
            state        <= ST_READ;
            word_forward <= forward;
          end
        end
        ST_READ: begin
          if (wb_ack) state <= ST_PUSH_FIRST;
        end
        ST_PUSH_FIRST: state <= ST_PUSH_SECOND;
        ST_PUSH_SECOND: begin
          state <= ST_IDLE;
          // A restart seen mid-read overrides the step
          if (restart || restart_pending) begin
            addr <= forward ? '0 : LAST_WORD_ADDR;
          end else begin
            addr <= addr_step;
          end
        end
        default: state <= ST_IDLE;
      endcase

      if (state != ST_IDLE && state != ST_PUSH_SECOND && restart) begin
        restart_pending <= 1'b1;
      end else if (state == ST_PUSH_SECOND) begin
        restart_pending <= 1'b0;
      end
    end
  end

  // Word register
  always_ff @(posedge clk) begin
    if (state == ST_READ && wb_ack) word_q <= wb_rdata;
  end

  assign wb_cyc = (state == ST_READ);
  assign wb_stb = (state == ST_READ);
  assign wb_adr = addr;

  assign push = (state == ST_PUSH_FIRST) || (state == ST_PUSH_SECOND);
  // Upper half first when forward, lower half first when backward
  assign push_data = ((state == ST_PUSH_FIRST) == word_forward) ? sample_t'(word_q[31:16])
                                                                : sample_t'(word_q[15:0]);

  // Classic handshake holds the request until ack
  assert property (@(posedge clk) disable iff (reset)
    (wb_stb && !wb_ack) |=> (wb_stb && $stable(wb_adr)));

endmodule

`default_nettype wire

// ==== verilog/playback_control.sv ====
`default_nettype none

module playback_control (
  input  logic                    clk,
  input  logic                    reset,
  input  simple_ipod_pkg::ascii_t key_ascii,
  input  logic                    key_valid,
  input  logic                    speed_up,
  input  logic                    speed_down,
  input  logic                    speed_reset,
  output logic                    playing,
  output logic                    forward,
  output logic                    restart,
  output simple_ipod_pkg::period_t sample_period
);

  import simple_ipod_pkg::*;

  logic cmd_play;
  logic cmd_pause;
  logic cmd_fwd;
  logic cmd_back;
  logic cmd_restart;

  // Key decode, either case accepted
  assign cmd_play    = key_valid && (key_ascii == KEY_UPPER_E || key_ascii == KEY_LOWER_E);
  assign cmd_pause   = key_valid && (key_ascii == KEY_UPPER_D || key_ascii == KEY_LOWER_D);
  assign cmd_fwd     = key_valid && (key_ascii == KEY_UPPER_F || key_ascii == KEY_LOWER_F);
  assign cmd_back    = key_valid && (key_ascii == KEY_UPPER_B || key_ascii == KEY_LOWER_B);
  assign cmd_restart = key_valid && (key_ascii == KEY_UPPER_R || key_ascii == KEY_LOWER_R);

  // ========================================
  // Run state and direction
  // ========================================
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      playing <= 1'b0;
      forward <= 1'b1;
      restart <= 1'b0;
    end else begin
      restart <= cmd_restart;  // One cycle only
      if (cmd_play) begin
        playing <= 1'b1;
      end else if (cmd_pause) begin
        playing <= 1'b0;
      end
      if (cmd_fwd) begin
        forward <= 1'b1;
      end else if (cmd_back) begin
        forward <= 1'b0;
      end
    end
  end

  // ========================================
  // Sample period, saturating
  // ========================================
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      sample_period <= SAMPLE_PERIOD_BASE;
    end else if (speed_reset) begin
      sample_period <= SAMPLE_PERIOD_BASE;
    end else if (speed_up) begin
      // Shorter period means faster playback
      if (sample_period <= PERIOD_MIN + PERIOD_STEP) begin
        sample_period <= PERIOD_MIN;
      end else begin
        sample_period <= sample_period - PERIOD_STEP;
      end
    end else if (speed_down) begin
      if (sample_period >= PERIOD_MAX - PERIOD_STEP) begin
        sample_period <= PERIOD_MAX;
      end else begin
        sample_period <= sample_period + PERIOD_STEP;
      end
    end
  end

  // Speed pulses arrive one at a time
  assert property (@(posedge clk) disable iff (reset)
    $onehot0({speed_up, speed_down, speed_reset}));

endmodule

`default_nettype wire

// ==== verilog/simple_ipod_pkg.sv ====
`default_nettype none

package simple_ipod_pkg;

  // ========================================
  // Widths
  // ========================================
  localparam int FLASH_ADDR_W = 23;
  localparam int FLASH_WORD_W = 32;
  localparam int SAMPLE_W     = 16;
  localparam int PERIOD_W     = 16;
  localparam int ASCII_W      = 8;

  typedef logic        [FLASH_ADDR_W-1:0] flash_addr_t;
  typedef logic        [FLASH_WORD_W-1:0] flash_word_t;  // Two samples per word
  typedef logic signed [SAMPLE_W-1:0]     sample_t;
  typedef logic        [PERIOD_W-1:0]     period_t;      // In clk cycles
  typedef logic        [ASCII_W-1:0]      ascii_t;

  // ========================================
  // Playback constants
  // ========================================
  // Audio region ends here, address wraps back to 0
  localparam flash_addr_t LAST_WORD_ADDR = 23'h7FFFF;

  localparam period_t SAMPLE_PERIOD_BASE = 16'd2272;  // ~22 kHz at 50 MHz
  localparam period_t PERIOD_STEP        = 16'd100;
  localparam period_t PERIOD_MIN         = 16'd1000;
  localparam period_t PERIOD_MAX         = 16'd5000;

  // Sample buffer
  localparam int FIFO_DEPTH   = 8;
  localparam int FIFO_PTR_W   = $clog2(FIFO_DEPTH);
  localparam int FIFO_COUNT_W = $clog2(FIFO_DEPTH + 1);  // Holds 0..FIFO_DEPTH

  // ========================================
  // Command keys
  // ========================================
  localparam ascii_t KEY_UPPER_D = 8'h44;  // Pause
  localparam ascii_t KEY_UPPER_E = 8'h45;  // Play
  localparam ascii_t KEY_UPPER_F = 8'h46;  // Forward
  localparam ascii_t KEY_UPPER_B = 8'h42;  // Backward
  localparam ascii_t KEY_UPPER_R = 8'h52;  // Restart

  localparam ascii_t KEY_LOWER_D = 8'h64;
  localparam ascii_t KEY_LOWER_E = 8'h65;
  localparam ascii_t KEY_LOWER_F = 8'h66;
  localparam ascii_t KEY_LOWER_B = 8'h62;
  localparam ascii_t KEY_LOWER_R = 8'h72;

endpackage

`default_nettype wire
